/* src/ntm_fixed_pkg.sv */
/*
  Fixed-point number format for the hidden gate datapath
  Signed Q4.12 words and the breakpoints of the piecewise-linear tanh
*/

package ntm_fixed_pkg;

  // Word format
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 12;

  // Magnitude of a word needs one extra bit for -8.0
  localparam int MAG_WIDTH  = DATA_WIDTH + 1;
  // Full product of two words
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic        [MAG_WIDTH-1:0]  mag_t;
  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  // Constants in Q4.12
  localparam data_t FX_ONE     = 16'sd4096;
  localparam data_t FX_QUARTER = 16'sd1024;

  // Tanh segments, linear below 0.5, saturated from 1.5
  localparam data_t SEG_LOW    = 16'sd2048;
  localparam data_t SEG_HIGH   = 16'sd6144;

endpackage

/* src/ntm_gate_ctrl_pkg.sv */
/*
  Control types of the hidden gate vector unit
  Vector length, input FSM states and the structs that carry one element
  from stage to stage
*/

package ntm_gate_ctrl_pkg;

  // Vector length, 1 to 255
  localparam int LENGTH_WIDTH = 8;

  typedef logic [LENGTH_WIDTH-1:0] length_t;

  // Input stage FSM
  // ISSUE is the cycle in which both request pulses are high
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    COLLECT = 2'd1,
    ISSUE   = 2'd2
  } input_state_t;

  // Paired s and o, input stage to tanh
  typedef struct packed {
    ntm_fixed_pkg::data_t s;
    ntm_fixed_pkg::data_t o;
    logic                 last;
  } gate_pair_t;

  // Tanh result with its o, tanh to multiplier
  typedef struct packed {
    ntm_fixed_pkg::data_t t;
    ntm_fixed_pkg::data_t o;
    logic                 last;
  } tanh_elem_t;

  // Hidden element, multiplier to output stage
  typedef struct packed {
    ntm_fixed_pkg::data_t h;
    logic                 last;
  } hidden_elem_t;

endpackage

/* src/ntm_gate_input_stage.sv */
/*
  Input stage of the hidden gate vector unit
  Latches the vector length on START, pulses the s and o requests and
  pairs the two answers, which may come in any order. The pair of the
  final element is tagged with last
*/

`timescale 1ns/1ps

module ntm_gate_input_stage (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  ntm_gate_ctrl_pkg::length_t    size_l,
  input  ntm_fixed_pkg::data_t          s_in,
  input  logic                          s_in_enable,
  input  ntm_fixed_pkg::data_t          o_in,
  input  logic                          o_in_enable,
  output logic                          s_request,
  output logic                          o_request,
  output ntm_gate_ctrl_pkg::gate_pair_t pair,
  output logic                          pair_valid
);

  ntm_gate_ctrl_pkg::input_state_t state;
  ntm_gate_ctrl_pkg::length_t      remaining;
  ntm_fixed_pkg::data_t            s_hold;
  ntm_fixed_pkg::data_t            o_hold;
  logic                            s_full;
  logic                            o_full;
  logic                            busy;
  logic                            pair_fire;
  logic                            last_elem;

  //////////////////////////////////////////////////////////////////////
  // Pairing
  //////////////////////////////////////////////////////////////////////

  assign busy = (state != ntm_gate_ctrl_pkg::IDLE);

  // Both halves present, held or arriving this cycle
  assign pair_fire = busy & (s_full | s_in_enable) & (o_full | o_in_enable);
  assign last_elem = (remaining == ntm_gate_ctrl_pkg::length_t'(1));

  // Requests straight from the state register
  assign s_request = (state == ntm_gate_ctrl_pkg::ISSUE);
  assign o_request = (state == ntm_gate_ctrl_pkg::ISSUE);

  //////////////////////////////////////////////////////////////////////
  // FSM and element count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_gate_ctrl_pkg::IDLE;
      remaining <= '0;
    end else begin
      case (state)
        ntm_gate_ctrl_pkg::IDLE: begin
          if (start) begin
            state     <= ntm_gate_ctrl_pkg::ISSUE;
            remaining <= size_l;
          end
        end
        ntm_gate_ctrl_pkg::COLLECT, ntm_gate_ctrl_pkg::ISSUE: begin
          if (pair_fire) begin
            remaining <= remaining - 1'b1;
            // Next request goes out with this pair
            state     <= last_elem ? ntm_gate_ctrl_pkg::IDLE : ntm_gate_ctrl_pkg::ISSUE;
          end else begin
            state <= ntm_gate_ctrl_pkg::COLLECT;
          end
        end
        default: begin
          state <= ntm_gate_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  // Full flags, cleared when the pair leaves
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s_full     <= 1'b0;
      o_full     <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= pair_fire;
      if (pair_fire) begin
        s_full <= 1'b0;
        o_full <= 1'b0;
      end else begin
        if (s_in_enable) s_full <= 1'b1;
        if (o_in_enable) o_full <= 1'b1;
      end
    end
  end

  // Holding registers and pair payload
  always_ff @(posedge CLK) begin
    if (s_in_enable) s_hold <= s_in;
    if (o_in_enable) o_hold <= o_in;
    if (pair_fire) begin
      pair.s    <= s_full ? s_hold : s_in;
      pair.o    <= o_full ? o_hold : o_in;
      pair.last <= last_elem;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////////////

  // One answer per request
  a_s_overrun: assert property (@(posedge CLK) disable iff (RST) s_in_enable |-> !s_full)
    else $error("s strobe while s element already held");
  a_o_overrun: assert property (@(posedge CLK) disable iff (RST) o_in_enable |-> !o_full)
    else $error("o strobe while o element already held");

  // No answers outside a vector
  a_idle_strobe: assert property (@(posedge CLK) disable iff (RST)
    (s_in_enable || o_in_enable) |-> busy)
    else $error("input strobe with no vector in progress");

  a_start_busy: assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
    else $error("START while a vector is in progress");
  a_zero_len: assert property (@(posedge CLK) disable iff (RST) start |-> size_l != '0)
    else $error("START with zero vector length");

endmodule

/* src/ntm_hidden_gate_vector.sv */
/*
  Hidden gate vector of the NTM controller, h = o * tanh(s)
  Elements stream in on request, pass through the tanh and multiplier
  pipeline and leave four cycles after the later input strobe
*/

`timescale 1ns/1ps

module ntm_hidden_gate_vector (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       START,
  output logic                       READY,
  input  logic                       S_IN_ENABLE,
  input  logic                       O_IN_ENABLE,
  output logic                       S_OUT_ENABLE,
  output logic                       O_OUT_ENABLE,
  output logic                       H_OUT_ENABLE,
  input  ntm_gate_ctrl_pkg::length_t SIZE_L_IN,
  input  ntm_fixed_pkg::data_t       S_IN,
  input  ntm_fixed_pkg::data_t       O_IN,
  output ntm_fixed_pkg::data_t       H_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  ntm_gate_ctrl_pkg::gate_pair_t   pair;
  logic                            pair_valid;
  ntm_gate_ctrl_pkg::tanh_elem_t   tanh_out;
  logic                            tanh_valid;
  ntm_gate_ctrl_pkg::hidden_elem_t prod;
  logic                            prod_valid;

  // Requests and pairing
  ntm_gate_input_stage input_stage (
    .CLK         (CLK),
    .RST         (RST),
    .start       (START),
    .size_l      (SIZE_L_IN),
    .s_in        (S_IN),
    .s_in_enable (S_IN_ENABLE),
    .o_in        (O_IN),
    .o_in_enable (O_IN_ENABLE),
    .s_request   (S_OUT_ENABLE),
    .o_request   (O_OUT_ENABLE),
    .pair        (pair),
    .pair_valid  (pair_valid)
  );

  // tanh(s), two cycles
  ntm_vector_tanh vector_tanh (
    .CLK        (CLK),
    .RST        (RST),
    .pair       (pair),
    .pair_valid (pair_valid),
    .tanh_out   (tanh_out),
    .tanh_valid (tanh_valid)
  );

  // o * tanh(s), one cycle
  ntm_vector_multiplier vector_multiplier (
    .CLK        (CLK),
    .RST        (RST),
    .tanh_in    (tanh_out),
    .tanh_valid (tanh_valid),
    .prod       (prod),
    .prod_valid (prod_valid)
  );

  // h register and READY
  ntm_hidden_output_stage output_stage (
    .CLK          (CLK),
    .RST          (RST),
    .prod         (prod),
    .prod_valid   (prod_valid),
    .h_out        (H_OUT),
    .h_out_enable (H_OUT_ENABLE),
    .ready        (READY)
  );

endmodule

/* src/ntm_hidden_output_stage.sv */
/*
  Output register of the hidden gate vector unit
  Holds h between strobes, pulses its enable and marks the end of the
  vector with READY
*/

`timescale 1ns/1ps

module ntm_hidden_output_stage (
  input  logic                            CLK,
  input  logic                            RST,
  input  ntm_gate_ctrl_pkg::hidden_elem_t prod,
  input  logic                            prod_valid,
  output ntm_fixed_pkg::data_t            h_out,
  output logic                            h_out_enable,
  output logic                            ready
);

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // h_out is visible at the port, cleared on reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      h_out <= '0;
    end else if (prod_valid) begin
      h_out <= prod.h;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      h_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      h_out_enable <= prod_valid;
      // Same cycle as the final h strobe
      ready        <= prod_valid & prod.last;
    end
  end

endmodule

/* src/ntm_vector_multiplier.sv */
/*
  Element product h = o * tanh(s) in Q4.12
  Full 32-bit product, floored back to a word by an arithmetic shift
*/

`timescale 1ns/1ps

module ntm_vector_multiplier (
  input  logic                            CLK,
  input  logic                            RST,
  input  ntm_gate_ctrl_pkg::tanh_elem_t   tanh_in,
  input  logic                            tanh_valid,
  output ntm_gate_ctrl_pkg::hidden_elem_t prod,
  output logic                            prod_valid
);

  ntm_fixed_pkg::prod_t full_prod;
  ntm_fixed_pkg::prod_t scaled;
  ntm_fixed_pkg::data_t h_next;

  //////////////////////////////////////////////////////////////////////
  // Product and rescale
  //////////////////////////////////////////////////////////////////////

  // Q8.24 product
  assign full_prod = tanh_in.o * tanh_in.t;

  // Back to Q4.12, rounds toward minus infinity
  assign scaled = full_prod >>> ntm_fixed_pkg::FRAC_BITS;
  assign h_next = scaled[ntm_fixed_pkg::DATA_WIDTH-1:0];

  always_ff @(posedge CLK) begin
    if (tanh_valid) begin
      prod.h    <= h_next;
      prod.last <= tanh_in.last;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= tanh_valid;
    end
  end

  // Bits dropped above the word are only sign copies
  a_prod_fits: assert property (@(posedge CLK) disable iff (RST)
    tanh_valid |-> scaled == ntm_fixed_pkg::prod_t'(h_next))
    else $error("hidden element overflows Q4.12");

endmodule

/* src/ntm_vector_tanh.sv */
/*
  Piecewise-linear tanh on the s element, two pipeline stages
  Stage 1 splits sign and magnitude, stage 2 picks the segment and
  restores the sign. o and last ride along unchanged
*/

`timescale 1ns/1ps

module ntm_vector_tanh (
  input  logic                          CLK,
  input  logic                          RST,
  input  ntm_gate_ctrl_pkg::gate_pair_t pair,
  input  logic                          pair_valid,
  output ntm_gate_ctrl_pkg::tanh_elem_t tanh_out,
  output logic                          tanh_valid
);

  logic signed [ntm_fixed_pkg::MAG_WIDTH-1:0] s_ext;
  ntm_fixed_pkg::mag_t                        s_abs;
  logic                                       s1_valid;
  logic                                       s1_sign;
  logic                                       s1_last;
  ntm_fixed_pkg::mag_t                        s1_mag;
  ntm_fixed_pkg::data_t                       s1_o;
  ntm_fixed_pkg::mag_t                        seg_mag;
  ntm_fixed_pkg::data_t                       seg_val;

  //////////////////////////////////////////////////////////////////////
  // Stage 1, sign and magnitude
  //////////////////////////////////////////////////////////////////////

  // 17 bits so that -8.0 has a magnitude
  assign s_ext = pair.s;
  assign s_abs = s_ext[ntm_fixed_pkg::MAG_WIDTH-1] ? -s_ext : s_ext;

  always_ff @(posedge CLK) begin
    if (pair_valid) begin
      s1_sign <= pair.s[ntm_fixed_pkg::DATA_WIDTH-1];
      s1_mag  <= s_abs;
      s1_o    <= pair.o;
      s1_last <= pair.last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2, segment select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (s1_mag < ntm_fixed_pkg::mag_t'(ntm_fixed_pkg::SEG_LOW)) begin
      // Linear, slope 1
      seg_mag = s1_mag;
    end else if (s1_mag < ntm_fixed_pkg::mag_t'(ntm_fixed_pkg::SEG_HIGH)) begin
      // Slope 1/2, meets 0.5 and 1.0 at the ends
      seg_mag = ntm_fixed_pkg::mag_t'(ntm_fixed_pkg::FX_QUARTER) + (s1_mag >> 1);
    end else begin
      seg_mag = ntm_fixed_pkg::mag_t'(ntm_fixed_pkg::FX_ONE);
    end
  end

  // Magnitude is at most 1.0 here, so the top bit is free
  assign seg_val = s1_sign ? -ntm_fixed_pkg::data_t'(seg_mag)
                           : ntm_fixed_pkg::data_t'(seg_mag);

  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      tanh_out.t    <= seg_val;
      tanh_out.o    <= s1_o;
      tanh_out.last <= s1_last;
    end
  end

  // Valid pipe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid   <= 1'b0;
      tanh_valid <= 1'b0;
    end else begin
      s1_valid   <= pair_valid;
      tanh_valid <= s1_valid;
    end
  end

  // Multiplier relies on |t| <= 1.0 for its range
  a_tanh_range: assert property (@(posedge CLK) disable iff (RST)
    tanh_valid |-> (tanh_out.t <= ntm_fixed_pkg::FX_ONE) &&
                   (tanh_out.t >= -ntm_fixed_pkg::FX_ONE))
    else $error("tanh magnitude above 1.0");

endmodule

/* tb/ntm_hidden_gate_model.svh */
/*
  Reference model of the hidden gate element
  Three-segment tanh, floored Q4.12 product and the stimulus LCG
*/

`ifndef NTM_HIDDEN_GATE_MODEL_SVH
`define NTM_HIDDEN_GATE_MODEL_SVH

// Stimulus generator seed
localparam logic [31:0] LCG_SEED = 32'd83;

// Tanh of a Q4.12 value held in an int, odd symmetric
function automatic int tanh_ref(input int s);
  int a;
  int r;
  a = (s < 0) ? -s : s;
  if (a < int'(ntm_fixed_pkg::SEG_LOW)) begin
    // Slope 1 near zero
    r = a;
  end else if (a < int'(ntm_fixed_pkg::SEG_HIGH)) begin
    // Slope 1/2 between 0.5 and 1.5
    r = int'(ntm_fixed_pkg::FX_QUARTER) + a / 2;
  end else begin
    r = int'(ntm_fixed_pkg::FX_ONE);
  end
  return (s < 0) ? -r : r;
endfunction

// h = o * tanh(s), rounded toward minus infinity
function automatic ntm_fixed_pkg::data_t hidden_ref(input int s, input int o);
  int p;
  p = o * tanh_ref(s);
  return ntm_fixed_pkg::data_t'(p >>> ntm_fixed_pkg::FRAC_BITS);
endfunction

// 32-bit LCG, usual multiplier and increment
function automatic logic [31:0] lcg_next(input logic [31:0] x);
  return x * 32'd1664525 + 32'd1013904223;
endfunction

`endif

/* tb/ntm_hidden_gate_vector_tb.sv */
/*
  Testbench of the hidden gate vector unit
  Answers s and o requests after chosen delays, checks every h element,
  its latency, the request counts and READY with concurrent assertions
*/

`timescale 1ns/1ps

module ntm_hidden_gate_vector_tb;

  `include "ntm_hidden_gate_model.svh"

  // 52 elements at about 9 cycles each plus 8 per vector come to about 700 cycles
  localparam int TIMEOUT_CYCLES = 4000;
  // Edge that samples the later strobe to the edge that sees H_OUT_ENABLE
  localparam int LATENCY_EDGES  = 5;

  logic CLK = 1'b0;
  logic RST;
  logic START;
  logic READY;
  logic S_IN_ENABLE;
  logic O_IN_ENABLE;
  logic S_OUT_ENABLE;
  logic O_OUT_ENABLE;
  logic H_OUT_ENABLE;
  ntm_gate_ctrl_pkg::length_t SIZE_L_IN;
  ntm_fixed_pkg::data_t       S_IN;
  ntm_fixed_pkg::data_t       O_IN;
  ntm_fixed_pkg::data_t       H_OUT;

  // Current vector stimulus
  ntm_fixed_pkg::data_t s_vals [256];
  ntm_fixed_pkg::data_t o_vals [256];
  int s_dly  [256];
  int o_dly  [256];
  int s_edge [256];
  int o_edge [256];

  // Expected results in output order over the whole run
  ntm_fixed_pkg::data_t exp_h [256];
  logic exp_last   [256];
  int   done_cycle [256];
  int   wr_count    = 0;
  int   out_count   = 0;
  int   vec_len     = 0;
  int   s_req_count = 0;
  int   o_req_count = 0;
  int   cycle       = 0;
  int   errors      = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  bit   started     = 1'b0;
  logic [31:0] rng;

  int seg_s [9] = '{0, 2047, -2047, 2048, -2048, 6143, 6144, 32767, -32768};
  int seg_o [2] = '{4096, -3000};

  ntm_hidden_gate_vector uut (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .S_IN_ENABLE  (S_IN_ENABLE),
    .O_IN_ENABLE  (O_IN_ENABLE),
    .S_OUT_ENABLE (S_OUT_ENABLE),
    .O_OUT_ENABLE (O_OUT_ENABLE),
    .H_OUT_ENABLE (H_OUT_ENABLE),
    .SIZE_L_IN    (SIZE_L_IN),
    .S_IN         (S_IN),
    .O_IN         (O_IN),
    .H_OUT        (H_OUT)
  );

  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (RST) out_count <= 0;
    else if (H_OUT_ENABLE) out_count <= out_count + 1;
    // Request counts restart with each vector
    if (START) begin
      s_req_count <= 0;
      o_req_count <= 0;
    end else begin
      if (S_OUT_ENABLE) s_req_count <= s_req_count + 1;
      if (O_OUT_ENABLE) o_req_count <= o_req_count + 1;
    end
  end

  always @(posedge CLK) begin
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the unit stopped answering", cycle);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Quiet through reset and until the first START
  a_reset_quiet: assert property (@(posedge CLK) (RST || !started) |->
    !S_OUT_ENABLE && !O_OUT_ENABLE && !H_OUT_ENABLE && !READY && H_OUT == '0)
    else begin
      errors++;
      $display("Outputs active during or right after reset at %0t", $time);
    end

  a_h_expected: assert property (@(posedge CLK) disable iff (RST)
    H_OUT_ENABLE |-> out_count < wr_count)
    else begin
      errors++;
      $display("H_OUT_ENABLE with no element outstanding at %0t", $time);
    end

  a_h_value: assert property (@(posedge CLK) disable iff (RST)
    H_OUT_ENABLE |-> H_OUT == exp_h[out_count])
    else begin
      errors++;
      $display("Fail at %0t: H_OUT %0d, expected %0d", $time, $sampled(H_OUT),
               exp_h[$sampled(out_count)]);
    end

  a_latency: assert property (@(posedge CLK) disable iff (RST)
    H_OUT_ENABLE |-> cycle == done_cycle[out_count] + LATENCY_EDGES)
    else begin
      errors++;
      $display("Fail at %0t: H_OUT_ENABLE at cycle %0d, expected cycle %0d", $time,
               $sampled(cycle), done_cycle[$sampled(out_count)] + LATENCY_EDGES);
    end

  // Held between strobes
  a_h_hold: assert property (@(posedge CLK) disable iff (RST)
    !H_OUT_ENABLE |-> $stable(H_OUT))
    else begin
      errors++;
      $display("Fail at %0t: H_OUT changed without a strobe", $time);
    end

  a_ready_last: assert property (@(posedge CLK) disable iff (RST)
    READY |-> H_OUT_ENABLE && exp_last[out_count])
    else begin
      errors++;
      $display("READY without the final H_OUT_ENABLE at %0t", $time);
    end

  a_last_ready: assert property (@(posedge CLK) disable iff (RST)
    H_OUT_ENABLE && exp_last[out_count] |-> READY)
    else begin
      errors++;
      $display("Final element came out without READY at %0t", $time);
    end

  a_s_req_extra: assert property (@(posedge CLK) disable iff (RST)
    S_OUT_ENABLE |-> s_req_count < vec_len)
    else begin
      errors++;
      $display("More s requests than the vector length at %0t", $time);
    end

  a_o_req_extra: assert property (@(posedge CLK) disable iff (RST)
    O_OUT_ENABLE |-> o_req_count < vec_len)
    else begin
      errors++;
      $display("More o requests than the vector length at %0t", $time);
    end

  a_req_total: assert property (@(posedge CLK) disable iff (RST)
    READY |-> s_req_count == vec_len && o_req_count == vec_len)
    else begin
      errors++;
      $display("Too few requests before READY at %0t", $time);
    end

  //////////////////////////////////////////////////////////////////////
  // Source side
  //////////////////////////////////////////////////////////////////////

  function automatic int next_random();
    rng = lcg_next(rng);
    return int'(rng[31:16]);
  endfunction

  // Delay counts edges after the edge that sees the request
  task automatic answer_channel(input bit is_o, input int len, input int base);
    int i;
    for (i = 0; i < len; i++) begin
      @(posedge CLK);
      while (!(is_o ? O_OUT_ENABLE : S_OUT_ENABLE)) @(posedge CLK);
      repeat (is_o ? o_dly[i] : s_dly[i]) @(posedge CLK);
      if (is_o) begin
        O_IN        <= o_vals[i];
        O_IN_ENABLE <= 1'b1;
        o_edge[i]    = cycle + 1;
      end else begin
        S_IN        <= s_vals[i];
        S_IN_ENABLE <= 1'b1;
        s_edge[i]    = cycle + 1;
      end
      // Element completes on the later of the two strobes
      done_cycle[base + i] = (s_edge[i] > o_edge[i]) ? s_edge[i] : o_edge[i];
      @(posedge CLK);
      if (is_o) O_IN_ENABLE <= 1'b0;
      else S_IN_ENABLE <= 1'b0;
    end
  endtask

  task automatic run_vector(input int len);
    int i;
    int base;
    base = wr_count;
    for (i = 0; i < len; i++) begin
      exp_h[base + i]      = hidden_ref(s_vals[i], o_vals[i]);
      exp_last[base + i]   = (i == len - 1);
      done_cycle[base + i] = 0;
      s_edge[i] = 0;
      o_edge[i] = 0;
    end
    @(posedge CLK);
    wr_count = base + len;
    vec_len  = len;
    started  = 1'b1;
    START     <= 1'b1;
    SIZE_L_IN <= ntm_gate_ctrl_pkg::length_t'(len);
    @(posedge CLK);
    START <= 1'b0;
    fork
      answer_channel(1'b0, len, base);
      answer_channel(1'b1, len, base);
    join
    while (!READY) @(posedge CLK);
  endtask

  task automatic fill_random(input int len, input int max_delay);
    int i;
    for (i = 0; i < len; i++) begin
      s_vals[i] = ntm_fixed_pkg::data_t'(next_random());
      o_vals[i] = ntm_fixed_pkg::data_t'(next_random());
      s_dly[i]  = next_random() % (max_delay + 1);
      o_dly[i]  = next_random() % (max_delay + 1);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    @(posedge CLK);
    if (out_count != wr_count) begin
      errors++;
      $display("Test %s: %0d results never came out", name, wr_count - out_count);
    end
    if (errors == errs_before) tests_passed++;
    else tests_failed++;
    $display("Test %s: %s", name, (errors == errs_before) ? "passed" : "failed");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int e0;
    int lens [3];
    RST         <= 1'b1;
    START       <= 1'b0;
    S_IN_ENABLE <= 1'b0;
    O_IN_ENABLE <= 1'b0;
    SIZE_L_IN   <= '0;
    S_IN        <= '0;
    O_IN        <= '0;
    rng = LCG_SEED;
    lens = '{1, 5, 16};

    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    repeat (5) @(posedge CLK);
    finish_test("reset", 0);

    // One element per vector with s on each segment boundary
    e0 = errors;
    for (int si = 0; si < 9; si++) begin
      for (int oi = 0; oi < 2; oi++) begin
        s_vals[0] = ntm_fixed_pkg::data_t'(seg_s[si]);
        o_vals[0] = ntm_fixed_pkg::data_t'(seg_o[oi]);
        s_dly[0]  = (si + oi) % 3;
        o_dly[0]  = (si + 2 * oi) % 3;
        run_vector(1);
      end
    end
    finish_test("segment edges", e0);

    // Independent delays put s and o in either order
    e0 = errors;
    foreach (lens[k]) begin
      fill_random(lens[k], 6);
      run_vector(lens[k]);
    end
    finish_test("random vectors", e0);

    // Immediate answers keep several elements in the pipeline
    e0 = errors;
    fill_random(12, 0);
    run_vector(12);
    finish_test("streaming", e0);

    $display("Tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tb
src/ntm_fixed_pkg.sv
src/ntm_gate_ctrl_pkg.sv
src/ntm_gate_input_stage.sv
src/ntm_vector_tanh.sv
src/ntm_vector_multiplier.sv
src/ntm_hidden_output_stage.sv
src/ntm_hidden_gate_vector.sv
tb/ntm_hidden_gate_vector_tb.sv
